/* logic/rvIsaPkg.sv */
package rvIsaPkg;

   // Data and instruction word
   typedef logic [31:0] word_t;

   // Register index into the 32-entry file
   typedef logic [4:0] regId_t;

   // Minor function field from bits 14 to 12
   typedef logic [2:0] funct3_t;

   // One bit per byte lane on the memory bus
   typedef logic [3:0] byteMask_t;

   // Major opcode in bits 6 to 2
   typedef logic [4:0] opcode_t;

   // Major opcodes of the base integer set
   localparam opcode_t opLoad   = 5'b00000;
   localparam opcode_t opAluImm = 5'b00100;
   localparam opcode_t opAuipc  = 5'b00101;
   localparam opcode_t opStore  = 5'b01000;
   localparam opcode_t opAluReg = 5'b01100;
   localparam opcode_t opLui    = 5'b01101;
   localparam opcode_t opBranch = 5'b11000;
   localparam opcode_t opJalr   = 5'b11001;
   localparam opcode_t opJal    = 5'b11011;
   localparam opcode_t opSystem = 5'b11100;

   // Instruction class after decoding
   // SYSTEM and unknown opcodes share classOther
   typedef enum logic [3:0] {
      classLoad,
      classAluImm,
      classAuipc,
      classStore,
      classAluReg,
      classLui,
      classBranch,
      classJalr,
      classJal,
      classOther
   } instrClass_t;

endpackage

/* logic/coreCfgPkg.sv */
package coreCfgPkg;

   // Sequencer states
   // Reset enters stWaitAluMem so a pending write drains first
   typedef enum logic [2:0] {
      stFetch,
      stWaitInstr,
      stExecute1,
      stExecute2,
      stWaitAluMem
   } coreState_t;

   // Internal address width, bus address is zero padded above it
   localparam int defaultAddrWidth = 24;

   // First fetch address, must be word aligned
   localparam logic [31:0] defaultResetAddr = 32'h0000_0000;

endpackage

/* logic/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder import rvIsaPkg::*; (
   input  word_t       instr,
   output instrClass_t instrClass,
   output funct3_t     funct3,
   output regId_t      rdId,
   output logic        altFunct,
   output word_t       immI,
   output word_t       immS,
   output word_t       immB,
   output word_t       immU,
   output word_t       immJ
);

   opcode_t opcode;

   // Bits 1 and 0 are always 11 in RV32I and carry no information
   assign opcode = instr[6:2];
   assign funct3 = instr[14:12];
   assign rdId   = instr[11:7];

   // Class from major opcode
   always_comb begin
      case (opcode)
         opLoad:   instrClass = classLoad;
         opAluImm: instrClass = classAluImm;
         opAuipc:  instrClass = classAuipc;
         opStore:  instrClass = classStore;
         opAluReg: instrClass = classAluReg;
         opLui:    instrClass = classLui;
         opBranch: instrClass = classBranch;
         opJalr:   instrClass = classJalr;
         opJal:    instrClass = classJal;
         // SYSTEM executes as a no-op
         opSystem: instrClass = classOther;
         default:  instrClass = classOther;
      endcase
   end

   // Bit 30 picks SUB and SRA
   // On ADDI this bit belongs to the immediate, so SUB needs the register form
   assign altFunct = instr[30] & ((opcode == opAluReg) | (funct3 == 3'b101));

   // Sign-extended immediates in the five encodings
   assign immI = {{21{instr[31]}}, instr[30:20]};
   assign immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   // Upper immediate fills bits 31 to 12
   assign immU = {instr[31:12], 12'h000};
   assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

/* logic/registerFile.sv */
`timescale 1ns/1ps

module registerFile import rvIsaPkg::*; (
   input  logic   clk,
   input  logic   capture,
   input  regId_t rs1Id,
   input  regId_t rs2Id,
   output word_t  rs1,
   output word_t  rs2,
   input  logic   writeEn,
   input  regId_t rdId,
   input  word_t  writeData
);

   word_t regs [32];

   // Write port, x0 stays untouched
   always_ff @(posedge clk) begin
      if (writeEn && (rdId != 5'd0)) begin
         regs[rdId] <= writeData;
      end
   end

   // Operand capture alongside the instruction word
   // x0 reads as zero even though its entry is never written
   always_ff @(posedge clk) begin
      if (capture) begin
         rs1 <= (rs1Id == 5'd0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == 5'd0) ? '0 : regs[rs2Id];
      end
   end

endmodule

/* logic/aluShifter.sv */
`timescale 1ns/1ps

module aluShifter import rvIsaPkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        start,
   input  instrClass_t instrClass,
   input  funct3_t     funct3,
   input  logic        altFunct,
   input  word_t       rs1,
   input  word_t       rs2,
   input  word_t       immI,
   output word_t       result,
   output logic        busy,
   output word_t       sum,
   output logic        predicate
);

   word_t       aluIn2;
   word_t       resultReg;
   logic [4:0]  shiftCount;
   logic [32:0] minus;
   logic        lt;
   logic        ltu;
   logic        eq;
   logic        isShift;

   // Register operand for register ALU ops and branches
   // I-immediate for everything else, JALR and loads included
   assign aluIn2 = ((instrClass == classAluReg) || (instrClass == classBranch)) ? rs2 : immI;

   // Adder shared with the JALR target
   assign sum = rs1 + aluIn2;

   // One 33-bit subtract gives SUB and all three comparisons
   assign minus = {1'b1, ~aluIn2} + {1'b0, rs1} + 33'd1;
   assign ltu   = minus[32];
   // Differing signs decide the signed compare directly
   assign lt    = (rs1[31] ^ aluIn2[31]) ? rs1[31] : minus[32];
   assign eq    = (minus[31:0] == 32'd0);

   assign isShift = (funct3 == 3'b001) || (funct3 == 3'b101);
   // Shift in progress while steps remain
   assign busy    = |shiftCount;
   assign result  = resultReg;

   // Shift step counter
   always_ff @(posedge clk) begin
      if (!reset) begin
         shiftCount <= 5'd0;
      end else if (start) begin
         shiftCount <= isShift ? aluIn2[4:0] : 5'd0;
      end else if (busy) begin
         shiftCount <= shiftCount - 5'd1;
      end
   end

   // Result register, or working operand during a shift
   always_ff @(posedge clk) begin
      if (start) begin
         case (funct3)
            3'b000:  resultReg <= altFunct ? minus[31:0] : sum;
            3'b010:  resultReg <= {31'd0, lt};
            3'b011:  resultReg <= {31'd0, ltu};
            3'b100:  resultReg <= rs1 ^ aluIn2;
            3'b110:  resultReg <= rs1 | aluIn2;
            3'b111:  resultReg <= rs1 & aluIn2;
            // Shifts start from rs1 unchanged
            default: resultReg <= rs1;
         endcase
      end else if (busy) begin
         // One bit per cycle, SRA copies the sign bit in
         resultReg <= (funct3 == 3'b001) ? {resultReg[30:0], 1'b0}
                                         : {altFunct & resultReg[31], resultReg[31:1]};
      end
   end

   // Branch condition, funct3 values 010 and 011 are not branches
   always_comb begin
      case (funct3)
         3'b000:  predicate = eq;
         3'b001:  predicate = !eq;
         3'b100:  predicate = lt;
         3'b101:  predicate = !lt;
         3'b110:  predicate = ltu;
         3'b111:  predicate = !ltu;
         default: predicate = 1'b0;
      endcase
   end

endmodule

/* logic/loadStoreUnit.sv */
`timescale 1ns/1ps

module loadStoreUnit import rvIsaPkg::*; #(
   parameter int addrWidth = 32
) (
   input  logic                 clk,
   input  logic                 capture,
   input  instrClass_t          instrClass,
   input  funct3_t              funct3,
   input  word_t                rs1,
   input  word_t                rs2,
   input  word_t                immI,
   input  word_t                immS,
   input  logic                 storeNow,
   input  word_t                memRdata,
   output logic [addrWidth-1:0] lsAddr,
   output word_t                memWdata,
   output byteMask_t            memWmask,
   output word_t                loadData
);

   word_t       offset;
   logic        byteAccess;
   logic        halfAccess;
   logic        loadSign;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;

   // Stores use the split S-immediate
   assign offset = (instrClass == classStore) ? immS : immI;

   // Effective address held through the access
   always_ff @(posedge clk) begin
      if (capture) begin
         lsAddr <= rs1[addrWidth-1:0] + offset[addrWidth-1:0];
      end
   end

   // Size from funct3 low bits
   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // Store data replicated so the active lanes hold the right bytes
   assign memWdata[7:0]   = rs2[7:0];
   assign memWdata[15:8]  = lsAddr[0] ? rs2[7:0] : rs2[15:8];
   assign memWdata[23:16] = lsAddr[1] ? rs2[7:0] : rs2[23:16];
   assign memWdata[31:24] = lsAddr[0] ? rs2[7:0] : (lsAddr[1] ? rs2[15:8] : rs2[31:24]);

   // Lane mask only while the store is issued
   always_comb begin
      if (!storeNow) begin
         memWmask = 4'b0000;
      end else if (byteAccess) begin
         memWmask = byteMask_t'(4'b0001 << lsAddr[1:0]);
      end else if (halfAccess) begin
         memWmask = lsAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         memWmask = 4'b1111;
      end
   end

   // Load lane select
   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];
   // funct3 bit 2 set means LBU or LHU
   assign loadSign = !funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                     memRdata;

endmodule

/* logic/coreSequencer.sv */
`timescale 1ns/1ps

module coreSequencer import rvIsaPkg::*, coreCfgPkg::*; #(
   parameter int    addrWidth = defaultAddrWidth,
   parameter word_t resetAddr = defaultResetAddr
) (
   input  logic                 clk,
   input  logic                 reset,
   input  word_t                memRdata,
   input  logic                 memRbusy,
   input  logic                 memWbusy,
   input  logic                 aluBusy,
   input  instrClass_t          instrClass,
   input  word_t                immB,
   input  word_t                immU,
   input  word_t                immJ,
   input  word_t                aluSum,
   input  logic                 predicate,
   input  word_t                aluResult,
   input  word_t                loadData,
   input  logic [addrWidth-1:0] lsAddr,
   output word_t                instr,
   output logic                 fetchCapture,
   output logic                 aluStart,
   output logic                 lsCapture,
   output logic                 storeNow,
   output logic                 regWriteEn,
   output word_t                writeData,
   output word_t                memAddr,
   output logic                 memRstrb
);

   coreState_t           state;
   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcPlusImm;
   logic [addrWidth-1:0] nextPc;
   logic [addrWidth-1:0] busAddr;
   word_t                targetImm;
   logic                 predicateReg;
   logic                 isAlu;
   logic                 isShift;
   logic                 needWait;
   logic                 writesReg;

   assign isAlu   = (instrClass == classAluImm) || (instrClass == classAluReg);
   assign pcPlus4 = pc + addrWidth'(4);

   // funct3 of 001 or 101 on an ALU op selects a shift
   assign isShift = isAlu && (instr[13:12] == 2'b01);

   // JAL, AUIPC and branches share one PC-relative adder
   assign targetImm = (instrClass == classJal)   ? immJ :
                      (instrClass == classAuipc) ? immU : immB;

   // JALR clears bit 0 of its target
   always_comb begin
      if (instrClass == classJalr) begin
         nextPc = {aluSum[addrWidth-1:1], 1'b0};
      end else if ((instrClass == classJal) || ((instrClass == classBranch) && predicateReg)) begin
         nextPc = pcPlusImm;
      end else begin
         nextPc = pcPlus4;
      end
   end

   // Loads, stores and shifts pass through the wait state
   assign needWait = (instrClass == classLoad) || (instrClass == classStore) || isShift;

   // Control state
   always_ff @(posedge clk) begin
      if (!reset) begin
         state        <= stWaitAluMem;
         pc           <= resetAddr[addrWidth-1:0];
         predicateReg <= 1'b0;
      end else begin
         case (state)
            stFetch: state <= stWaitInstr;
            stWaitInstr: begin
               if (!memRbusy) begin
                  state <= stExecute1;
               end
            end
            stExecute1: begin
               predicateReg <= predicate;
               state        <= stExecute2;
            end
            stExecute2: begin
               pc    <= nextPc;
               state <= needWait ? stWaitAluMem : stFetch;
            end
            stWaitAluMem: begin
               if (!aluBusy && !memRbusy && !memWbusy) begin
                  state <= stFetch;
               end
            end
            default: state <= stFetch;
         endcase
      end
   end

   // Instruction latch and registered branch target
   always_ff @(posedge clk) begin
      if (fetchCapture) begin
         instr <= memRdata;
      end
      if (state == stExecute1) begin
         pcPlusImm <= pc + targetImm[addrWidth-1:0];
      end
   end

   // Unit strobes
   assign fetchCapture = (state == stWaitInstr) && !memRbusy;
   assign aluStart     = (state == stExecute1) && isAlu;
   assign lsCapture    = (state == stExecute1);
   assign storeNow     = (state == stExecute2) && (instrClass == classStore);

   // Rewritten each wait cycle so the final shift step or load data lands
   assign writesReg  = (instrClass != classBranch) && (instrClass != classStore) &&
                       (instrClass != classOther);
   assign regWriteEn = writesReg && ((state == stExecute2) || (state == stWaitAluMem));

   // Write-back value per class
   always_comb begin
      case (instrClass)
         classLui:    writeData = immU;
         classAuipc:  writeData = word_t'(pcPlusImm);
         classAluImm: writeData = aluResult;
         classAluReg: writeData = aluResult;
         classJal:    writeData = word_t'(pcPlus4);
         classJalr:   writeData = word_t'(pcPlus4);
         classLoad:   writeData = loadData;
         default:     writeData = '0;
      endcase
   end

   // PC on the bus while fetching and the load/store address otherwise
   assign busAddr  = ((state == stFetch) || (state == stWaitInstr)) ? pc : lsAddr;
   assign memAddr  = word_t'(busAddr);
   assign memRstrb = (state == stFetch) || ((state == stExecute2) && (instrClass == classLoad));

endmodule

/* logic/femtoCore.sv */
`timescale 1ns/1ps

module femtoCore import rvIsaPkg::*, coreCfgPkg::*; #(
   parameter int    addrWidth = defaultAddrWidth,
   parameter word_t resetAddr = defaultResetAddr
) (
   input  logic      clk,
   input  logic      reset,
   output word_t     memAddr,
   output word_t     memWdata,
   output byteMask_t memWmask,
   input  word_t     memRdata,
   output logic      memRstrb,
   input  logic      memRbusy,
   input  logic      memWbusy
);

   // Decoded instruction
   word_t       instr;
   instrClass_t instrClass;
   funct3_t     funct3;
   regId_t      rdId;
   logic        altFunct;
   word_t       immI;
   word_t       immS;
   word_t       immB;
   word_t       immU;
   word_t       immJ;

   // Datapath values
   word_t                rs1;
   word_t                rs2;
   word_t                aluResult;
   word_t                aluSum;
   logic                 aluBusy;
   logic                 predicate;
   logic [addrWidth-1:0] lsAddr;
   word_t                loadData;
   word_t                writeData;

   // Sequencer strobes
   logic fetchCapture;
   logic aluStart;
   logic lsCapture;
   logic storeNow;
   logic regWriteEn;

   instrDecoder decoder (
      .instr(instr), .instrClass(instrClass), .funct3(funct3), .rdId(rdId),
      .altFunct(altFunct), .immI(immI), .immS(immS), .immB(immB), .immU(immU), .immJ(immJ)
   );

   // Source indices come straight off the bus with the instruction word
   registerFile regFile (
      .clk(clk), .capture(fetchCapture), .rs1Id(memRdata[19:15]), .rs2Id(memRdata[24:20]),
      .rs1(rs1), .rs2(rs2), .writeEn(regWriteEn), .rdId(rdId), .writeData(writeData)
   );

   aluShifter alu (
      .clk(clk), .reset(reset), .start(aluStart), .instrClass(instrClass), .funct3(funct3),
      .altFunct(altFunct), .rs1(rs1), .rs2(rs2), .immI(immI), .result(aluResult),
      .busy(aluBusy), .sum(aluSum), .predicate(predicate)
   );

   loadStoreUnit #(.addrWidth(addrWidth)) lsu (
      .clk(clk), .capture(lsCapture), .instrClass(instrClass), .funct3(funct3),
      .rs1(rs1), .rs2(rs2), .immI(immI), .immS(immS), .storeNow(storeNow),
      .memRdata(memRdata), .lsAddr(lsAddr), .memWdata(memWdata), .memWmask(memWmask),
      .loadData(loadData)
   );

   coreSequencer #(.addrWidth(addrWidth), .resetAddr(resetAddr)) sequencer (
      .clk(clk), .reset(reset), .memRdata(memRdata), .memRbusy(memRbusy),
      .memWbusy(memWbusy), .aluBusy(aluBusy), .instrClass(instrClass), .immB(immB),
      .immU(immU), .immJ(immJ), .aluSum(aluSum), .predicate(predicate),
      .aluResult(aluResult), .loadData(loadData), .lsAddr(lsAddr), .instr(instr),
      .fetchCapture(fetchCapture), .aluStart(aluStart), .lsCapture(lsCapture),
      .storeNow(storeNow), .regWriteEn(regWriteEn), .writeData(writeData),
      .memAddr(memAddr), .memRstrb(memRstrb)
   );

endmodule

/* tb/femtoCore_assertions.sv */
`timescale 1ns/1ps

module femtoCoreAssertions import rvIsaPkg::*; (
   input logic      clk,
   input logic      reset,
   input logic      memRstrb,
   input byteMask_t memWmask
);

   // A cycle either reads or writes, never both
   readWriteExclusive: assert property (
      @(posedge clk) disable iff (!reset) !(memRstrb && (memWmask != 4'b0000))
   ) else $error("memRstrb and memWmask active in the same cycle");

   // Read strobe is a single-cycle pulse
   singleCycleStrobe: assert property (
      @(posedge clk) disable iff (!reset) memRstrb |=> !memRstrb
   ) else $error("memRstrb high in two consecutive cycles");

   // Reset leaves no write pending on the bus
   noWriteAfterReset: assert property (
      @(posedge clk) !reset |=> (memWmask == 4'b0000)
   ) else $error("memWmask not zero in the cycle after reset");

endmodule

// Attached to every core instance
bind femtoCore femtoCoreAssertions handshakeChecks (
   .clk(clk),
   .reset(reset),
   .memRstrb(memRstrb),
   .memWmask(memWmask)
);

/* tb/tbFemtoCore.sv */
`timescale 1ns/1ps

module tbFemtoCore import rvIsaPkg::*, coreCfgPkg::*; ();

   localparam int          period        = 100;
   localparam int          resetCycles   = 3;
   localparam int          cyclesPerStep = 40;
   localparam int          tailCycles    = 100;
   localparam int          memWords      = 1024;
   localparam int          dataWords     = 512;
   // Expected store records start at this word of the data file
   localparam int          recordBase    = 256;
   localparam word_t       resetAddr     = defaultResetAddr;
   localparam word_t       endMark       = 32'hFFFF_FFFF;
   localparam int unsigned randomSeed    = 32'h0701_735e;

   logic      clk;
   logic      reset;
   word_t     memAddr;
   word_t     memWdata;
   byteMask_t memWmask;
   word_t     memRdata;
   logic      memRstrb;
   logic      memRbusy;
   logic      memWbusy;

   word_t testData [dataWords];
   word_t mem [memWords];
   int    programWords;
   int    recordCount;
   int    recordIndex;
   int    passCount;
   int    failCount;
   int    readWait;
   int    writeWait;
   bit    dataLoaded;
   bit    firstFetchSeen;

   // Bus values sampled mid-cycle
   logic      seenRstrb;
   word_t     seenAddr;
   word_t     seenWdata;
   byteMask_t seenWmask;

   femtoCore #(.addrWidth(defaultAddrWidth), .resetAddr(resetAddr)) UUT (
      .clk(clk), .reset(reset), .memAddr(memAddr), .memWdata(memWdata),
      .memWmask(memWmask), .memRdata(memRdata), .memRstrb(memRstrb),
      .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   // Background pattern for words outside the program
   function automatic word_t fillWord(int index);
      return word_t'(index) * 32'h9E37_79B9 ^ 32'h5A5A_0000;
   endfunction

   // Program image followed by records of address, data and mask
   task automatic loadTestData();
      int i;
      for (i = 0; i < dataWords; i++) begin
         testData[i] = endMark;
      end
      $readmemh("tb/femtoCore_testdata.mem", testData);
      programWords = 0;
      while ((programWords < recordBase) && (testData[programWords] != endMark)) begin
         programWords++;
      end
      recordCount = 0;
      while ((recordBase + 3 * recordCount + 2 < dataWords) &&
             (testData[recordBase + 3 * recordCount] != endMark)) begin
         recordCount++;
      end
      for (i = 0; i < memWords; i++) begin
         mem[i] = (i < programWords) ? testData[i] : fillWord(i);
      end
   endtask

   task automatic checkFirstFetch(input word_t addr);
      assert (addr == resetAddr) else begin
         $display("Error at %0t ns: first fetch from %h, expected %h", $time, addr, resetAddr);
      end
      if (addr == resetAddr) begin
         passCount++;
         $display("test 0: first fetch from %h passed", addr);
      end else begin
         failCount++;
         $display("test 0: first fetch from %h failed", addr);
      end
      firstFetchSeen = 1'b1;
   endtask

   // Compare one observed store with the next expected record
   task automatic checkStore(input word_t addr, input word_t data, input byteMask_t mask);
      int        base;
      word_t     expAddr;
      word_t     expData;
      word_t     laneBits;
      byteMask_t expMask;
      bit        match;
      assert (recordIndex < recordCount) else begin
         $display("Unexpected extra store of %h to address %h", data, addr);
         failCount++;
      end
      if (recordIndex < recordCount) begin
         base     = recordBase + 3 * recordIndex;
         expAddr  = testData[base];
         expData  = testData[base + 1];
         expMask  = testData[base + 2][3:0];
         // Only the written lanes carry meaning
         laneBits = {{8{expMask[3]}}, {8{expMask[2]}}, {8{expMask[1]}}, {8{expMask[0]}}};
         match    = (addr == expAddr) && (mask == expMask) &&
                    ((data & laneBits) == (expData & laneBits));
         assert (match) else begin
            $display("Error at %0t ns: store %0d wrote %h mask %b to %h, expected %h %b to %h",
                     $time, recordIndex + 1, data, mask, addr, expData, expMask, expAddr);
         end
         if (match) begin
            passCount++;
            $display("test %0d: store to %h passed", recordIndex + 1, addr);
         end else begin
            failCount++;
            $display("test %0d: store to %h failed", recordIndex + 1, addr);
         end
         recordIndex++;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   always @(negedge clk) begin
      seenRstrb = memRstrb;
      seenAddr  = memAddr;
      seenWdata = memWdata;
      seenWmask = memWmask;
   end

   // Memory model with random busy stretches of 0 to 3 cycles
   always @(posedge clk) begin
      int index;
      int lane;
      if (!reset) begin
         memRbusy  <= 1'b0;
         memWbusy  <= 1'b0;
         readWait  = 0;
         writeWait = 0;
      end else begin
         index = int'(seenAddr[11:2]);
         if (seenRstrb) begin
            if (!firstFetchSeen) begin
               checkFirstFetch(seenAddr);
            end
            readWait = int'($urandom % 4);
            memRdata <= mem[index];
            memRbusy <= (readWait != 0);
         end else if (readWait != 0) begin
            readWait--;
            memRbusy <= (readWait != 0);
         end
         if (seenWmask != 4'b0000) begin
            for (lane = 0; lane < 4; lane++) begin
               if (seenWmask[lane]) begin
                  mem[index][8 * lane +: 8] = seenWdata[8 * lane +: 8];
               end
            end
            checkStore(seenAddr, seenWdata, seenWmask);
            writeWait = int'($urandom % 4);
            memWbusy <= (writeWait != 0);
         end else if (writeWait != 0) begin
            writeWait--;
            memWbusy <= (writeWait != 0);
         end
      end
   end

   initial begin
      reset          = 1'b0;
      memRdata       = '0;
      memRbusy       = 1'b0;
      memWbusy       = 1'b0;
      recordIndex    = 0;
      passCount      = 0;
      failCount      = 0;
      readWait       = 0;
      writeWait      = 0;
      firstFetchSeen = 1'b0;
      void'($urandom(randomSeed));
      loadTestData();
      dataLoaded = 1'b1;
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b1;
      wait (recordIndex >= recordCount);
      // Extra cycles catch stores beyond the last record
      repeat (tailCycles) @(posedge clk);
      $display("%0d checks passed, %0d checks failed", passCount, failCount);
      if (failCount == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // Watchdog sized from program and record counts
   initial begin
      int limitCycles;
      wait (dataLoaded);
      limitCycles = (programWords + recordCount) * cyclesPerStep + resetCycles + tailCycles;
      repeat (limitCycles) @(posedge clk);
      $display("Timeout after %0d cycles with %0d of %0d stores seen",
               limitCycles, recordIndex, recordCount);
      $display("tests failed");
      $finish;
   end

endmodule

/* project.f */
logic/rvIsaPkg.sv
logic/coreCfgPkg.sv
logic/instrDecoder.sv
logic/registerFile.sv
logic/aluShifter.sv
logic/loadStoreUnit.sv
logic/coreSequencer.sv
logic/femtoCore.sv
tb/femtoCore_assertions.sv
tb/tbFemtoCore.sv

/* Makefile */
# Verilator build and run for the femtoCore testbench

VERILATOR ?= verilator
TOP       ?= tbFemtoCore
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_TEXT ?= tests failed
PASS_TEXT ?= all tests passed
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation OK"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/femtoCore_testdata.mem */
// Words 0 to 255 hold the program image, four instructions per line
// From word 256 each line is one expected store: address, data, lane mask
20000513 123450B7 67808093 00152023 // x10 base, lui/addi x1, sw x1
FFB00113 402081B3 00352223 00112233 // x2 = -5, sub, sw, slt
001132B3 00452423 00552623 0FF0C313 // sltu, two stores, xori
002373B3 1003E393 00752823 00001417 // and, ori, sw, auipc
00852A23 00409493 00952C23 41F15593 // sw, slli 4, sw, srai 31
00B52E23 0000D633 02C52023 01C15693 // sw, srl by x0, sw, srli 28
02D52223 021504A3 02251723 02E51703 // sw, sb, sh, lh
02E55783 02F54803 02950883 00052903 // lhu, lbu, lb, lw
02E52823 02F52A23 03052C23 03152E23 // store loaded values
05252023 00000A13 00000A93 00108463 // sw, clear x20 x21, beq taken
001A0A13 00209463 001A0A13 00114463 // bne taken, blt taken
001A0A13 0020D463 001A0A13 0020E463 // bge taken, bltu taken
001A0A13 00117463 001A0A13 00208463 // bgeu taken, beq untaken
001A8A93 00109463 001A8A93 0020C463 // bne untaken, blt untaken
001A8A93 00115463 001A8A93 00116463 // bge untaken, bltu untaken
001A8A93 0020F463 001A8A93 05452223 // bgeu untaken, sw x20
05552423 00800B6F 04052623 05652823 // sw x21, jal over marker, sw link
11B00B93 002B8C67 04052623 05852A23 // jalr over marker, sw link
00000073 04152C23 0000006F          // ecall no-op, final store, loop
@100
00000200 12345678 0000000F
00000204 1234567D 0000000F
00000208 00000001 0000000F
0000020C 00000000 0000000F
00000210 12345783 0000000F
00000214 0000103C 0000000F
00000218 23456780 0000000F
0000021C FFFFFFFF 0000000F
00000220 12345678 0000000F
00000224 0000000F 0000000F
00000229 78787878 00000002
0000022E FFFBFFFB 0000000C
00000230 FFFFFFFB 0000000F
00000234 0000FFFB 0000000F
00000238 000000FF 0000000F
0000023C 00000078 0000000F
00000240 12345678 0000000F
00000244 00000000 0000000F
00000248 00000006 0000000F
00000250 00000108 0000000F
00000254 00000118 0000000F
00000258 12345678 0000000F
